/* sources.f */
romload_pkg.sv
dl_byte_packer.sv
dl_write_fifo.sv
sdram_port_writer.sv
core_reset_ctrl.sv
rom_loader_top.sv
tb_clock_gen.sv
tb_rom_loader.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_rom_loader
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

/* tb_rom_loader.sv */
module tb_rom_loader;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		romload_pkg::mem_addr_t addr;
		romload_pkg::byte_sel_t ds;
		romload_pkg::mem_data_t data;
	} write_t;

	localparam int FIFO_DEPTH   = 4;
	localparam int RESET_CYCLES = 8;
	localparam int WD_MARGIN    = 1500;  // covers reset, the drain of a slow memory and the last checks
	localparam int LOAD_LIMIT   = 1200;

	logic                     clock_49;
	logic                     rst;
	logic                     ioctl_download;
	logic [7:0]               ioctl_index;
	logic                     ioctl_wr;
	romload_pkg::ioctl_addr_t ioctl_addr;
	romload_pkg::rom_byte_t   ioctl_dout;
	logic                     reset_req;
	logic                     mem_ack;
	logic                     mem_req;
	romload_pkg::mem_addr_t   mem_addr;
	romload_pkg::byte_sel_t   mem_ds;
	romload_pkg::mem_data_t   mem_data;
	logic                     overflow;
	logic                     rom_loaded;
	logic                     core_reset;

	romload_pkg::ioctl_addr_t st_addr[$];  // bytes of the current download
	romload_pkg::rom_byte_t   st_data[$];
	logic [7:0]               st_index[$];
	int                       st_gap[$];   // cycles to the next ioctl_wr

	write_t      exp_q[$];
	write_t      got_q[$];  // seen on the memory port but not yet compared
	int          exp_pos;
	bit          subseq_mode;  // writes may be dropped
	bit          slow_mem;
	bit          mem_busy;
	int          ack_delay;
	int          rec_cnt;
	int          chk_cnt;
	int          err_cnt;
	int          cycle_cnt;
	int          deadline;
	logic [31:0] lfsr_state;

	tb_clock_gen #(.PERIOD_NS(8)) clk_gen (.clock_49(clock_49));

	rom_loader_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_rom_loader_top (
		.clock_49       (clock_49),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_req      (reset_req),
		.mem_ack        (mem_ack),
		.mem_req        (mem_req),
		.mem_addr       (mem_addr),
		.mem_ds         (mem_ds),
		.mem_data       (mem_data),
		.overflow       (overflow),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	task automatic take_bits(input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic add_byte(input romload_pkg::ioctl_addr_t a, input logic [7:0] idx);
		int unsigned v;
		st_addr.push_back(a);
		st_index.push_back(idx);
		take_bits(8, v);
		st_data.push_back(v[7:0]);
		take_bits(3, v);
		st_gap.push_back(4 + int'(v));  // 4 to 11 cycles
	endtask

	// ordered writes that the mapping rules give for the byte list
	function automatic void expected_writes();
		bit                       held;
		romload_pkg::ioctl_addr_t held_addr;
		romload_pkg::rom_byte_t   held_data;
		romload_pkg::ioctl_addr_t a;
		romload_pkg::ioctl_addr_t off;
		romload_pkg::rom_byte_t   d;
		exp_q.delete();
		held      = 1'b0;
		held_addr = '0;
		held_data = '0;
		for (int i = 0; i < st_addr.size(); i++) begin
			if (st_index[i] != romload_pkg::ROM_INDEX)
				continue;
			a = st_addr[i];
			d = st_data[i];
			if (held && a < romload_pkg::GFX_BASE && a[0] && a[23:1] == held_addr[23:1]) begin
				exp_q.push_back({a[23:1], 2'b11, d, held_data});  // completed pair
				held = 1'b0;
				continue;
			end
			if (held) begin
				exp_q.push_back({held_addr[23:1], 2'b01, held_data, held_data});
				held = 1'b0;
			end
			if (a >= romload_pkg::GFX_BASE) begin
				off = a - romload_pkg::GFX_BASE;
				exp_q.push_back({off[23:16], off[14:0], (off[15] ? 2'b01 : 2'b10), d, d});
			end else if (!a[0]) begin
				held      = 1'b1;
				held_addr = a;
				held_data = d;
			end else begin
				exp_q.push_back({a[23:1], 2'b10, d, d});  // lone odd
			end
		end
		if (held)  // flushed by the end of the download
			exp_q.push_back({held_addr[23:1], 2'b01, held_data, held_data});
	endfunction

	task automatic check_value(input string what, input int got, input int want);
		chk_cnt++;
		assert (got == want) else begin
			err_cnt++;
			$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_reset_values();
		check_value("mem_req after reset", int'(mem_req), 0);
		check_value("overflow after reset", int'(overflow), 0);
		check_value("rom_loaded after reset", int'(rom_loaded), 0);
		check_value("core_reset after reset", int'(core_reset), 1);
	endtask

	task automatic clear_lists();
		st_addr.delete();
		st_data.delete();
		st_index.delete();
		st_gap.delete();
	endtask

	task automatic build_fast_list();
		int unsigned r;
		clear_lists();
		for (int i = 0; i < 8; i++)
			add_byte(25'(32'h100 + i), 8'd0);  // four pairs
		add_byte(romload_pkg::GFX_BASE + 25'h00000, 8'd0);
		add_byte(romload_pkg::GFX_BASE + 25'h00001, 8'd0);
		add_byte(romload_pkg::GFX_BASE + 25'h08000, 8'd0);
		add_byte(romload_pkg::GFX_BASE + 25'h08001, 8'd0);
		add_byte(romload_pkg::GFX_BASE + 25'h12345, 8'd0);
		add_byte(romload_pkg::GFX_BASE + 25'h18abc, 8'd0);
		add_byte(25'h200, 8'd0);  // lone even
		add_byte(25'h300, 8'd1);  // other index is ignored
		add_byte(25'h301, 8'd1);
		add_byte(25'h400, 8'd0);
		add_byte(25'h403, 8'd0);  // odd of another word
		for (int i = 0; i < 6; i++) begin
			take_bits(17, r);
			add_byte(25'(r), 8'd0);  // either region
		end
		add_byte(25'h500, 8'd0);  // held until download ends
	endtask

	task automatic build_slow_list();
		int unsigned r;
		clear_lists();
		for (int i = 0; i < 16; i++)
			add_byte(25'(32'h1000 + i), 8'd0);
		for (int i = 0; i < 16; i++) begin
			take_bits(16, r);
			add_byte(romload_pkg::GFX_BASE + 25'(r), 8'd0);
		end
	endtask

	task automatic send_bytes();
		@(negedge clock_49);
		ioctl_download = 1'b1;
		repeat (3) @(negedge clock_49);
		for (int i = 0; i < st_addr.size(); i++) begin
			ioctl_addr  = st_addr[i];
			ioctl_dout  = st_data[i];
			ioctl_index = st_index[i];
			ioctl_wr    = 1'b1;
			@(negedge clock_49);
			ioctl_wr = 1'b0;
			repeat (st_gap[i] - 1) @(negedge clock_49);
			check_value("rom_loaded during download", int'(rom_loaded), 0);
		end
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
	endtask

	task automatic wait_loaded();
		int n;
		n = 0;
		while (rom_loaded !== 1'b1 && n < LOAD_LIMIT) begin
			@(negedge clock_49);
			n++;
		end
		chk_cnt++;
		assert (rom_loaded === 1'b1) else begin
			err_cnt++;
			$display("rom_loaded did not rise within %0d cycles after the download", LOAD_LIMIT);
		end
		check_value("memory busy at rom_loaded", int'(mem_busy || mem_ack != mem_req), 0);
	endtask

	// memory responder that serves one write at a time
	initial begin
		int unsigned v;
		mem_ack   = 1'b0;
		mem_busy  = 1'b0;
		ack_delay = 0;
		rec_cnt   = 0;
		forever begin
			@(negedge clock_49);
			if (rst) begin
				mem_ack  = 1'b0;
				mem_busy = 1'b0;
			end else if (mem_busy) begin
				if (ack_delay <= 1) begin
					mem_ack  = mem_req;  // ends the write
					mem_busy = 1'b0;
				end else begin
					ack_delay--;
				end
			end else if (mem_req != mem_ack) begin
				got_q.push_back({mem_addr, mem_ds, mem_data});
				rec_cnt++;
				mem_busy = 1'b1;
				take_bits(slow_mem ? 5 : 1, v);
				ack_delay = slow_mem ? 64 + int'(v) : 1 + int'(v);
			end
		end
	end

	// compare recorded writes against the reference list
	initial begin
		write_t w;
		forever begin
			@(posedge clock_49);
			while (got_q.size() > 0) begin
				w = got_q.pop_front();
				chk_cnt++;
				if (subseq_mode) begin
					while (exp_pos < exp_q.size() && exp_q[exp_pos] != w)
						exp_pos++;
					assert (exp_pos < exp_q.size()) else begin
						err_cnt++;
						$display("ERROR %0t: write addr %h ds %b data %h is out of order",
							$time, w.addr, w.ds, w.data);
					end
				end else begin
					assert (exp_pos < exp_q.size() && exp_q[exp_pos] == w) else begin
						err_cnt++;
						$display("ERROR %0t: write %0d is addr %h ds %b data %h, expected %h",
							$time, exp_pos, w.addr, w.ds, w.data, exp_q[exp_pos]);
					end
				end
				exp_pos++;
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt <= deadline) begin
			@(posedge clock_49);
			cycle_cnt++;
		end
		$display("watchdog expired after %0d cycles, the test did not finish", cycle_cnt);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		rst            = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		reset_req      = 1'b0;
		lfsr_state     = 32'h7d2a;
		err_cnt        = 0;
		chk_cnt        = 0;
		exp_pos        = 0;
		subseq_mode    = 1'b0;
		slow_mem       = 1'b0;
		deadline       = 100;
		repeat (RESET_CYCLES) @(negedge clock_49);
		rst = 1'b0;
		@(negedge clock_49);
		check_reset_values();

		// fast memory where every write must arrive
		build_fast_list();
		expected_writes();
		exp_pos  = 0;
		rec_cnt  = 0;
		deadline = cycle_cnt + st_addr.size() * 12 * 2 + WD_MARGIN;
		send_bytes();
		wait_loaded();
		check_value("writes at rom_loaded", rec_cnt, exp_q.size());
		@(posedge clock_49);
		@(negedge clock_49);
		check_value("writes compared", exp_pos, exp_q.size());
		check_value("overflow with fast memory", int'(overflow), 0);
		repeat (2) @(negedge clock_49);
		check_value("core_reset after load", int'(core_reset), 0);
		reset_req = 1'b1;
		repeat (2) @(negedge clock_49);
		check_value("core_reset with reset_req", int'(core_reset), 1);
		reset_req = 1'b0;
		repeat (2) @(negedge clock_49);
		check_value("core_reset after reset_req", int'(core_reset), 0);

		// slow memory that runs the credits out
		@(negedge clock_49);
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock_49);
		rst = 1'b0;
		@(negedge clock_49);
		check_reset_values();
		slow_mem    = 1'b1;
		subseq_mode = 1'b1;
		build_slow_list();
		expected_writes();
		exp_pos  = 0;
		rec_cnt  = 0;
		deadline = cycle_cnt + st_addr.size() * 12 * 2 + WD_MARGIN;
		send_bytes();
		wait_loaded();
		@(posedge clock_49);
		@(negedge clock_49);
		check_value("overflow with slow memory", int'(overflow), 1);
		check_value("no write reached memory", int'(rec_cnt == 0), 0);
		check_value("core_reset after slow load", int'(core_reset), 0);

		// a reset clears the sticky overflow
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock_49);
		rst = 1'b0;
		@(negedge clock_49);
		check_reset_values();

		$display("%0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int PERIOD_NS = 8
) (
	output logic clock_49
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clock_49 = 1'b0;

	always #(PERIOD_NS / 2) clock_49 = ~clock_49;  // 50 % duty

endmodule

/* rom_loader_top.sv */
module rom_loader_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                     clock_49,
	input  logic                     rst,
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  logic                     ioctl_wr,
	input  romload_pkg::ioctl_addr_t ioctl_addr,
	input  romload_pkg::rom_byte_t   ioctl_dout,
	input  logic                     reset_req,
	input  logic                     mem_ack,
	output logic                     mem_req,
	output romload_pkg::mem_addr_t   mem_addr,
	output romload_pkg::byte_sel_t   mem_ds,
	output romload_pkg::mem_data_t   mem_data,
	output logic                     overflow,
	output logic                     rom_loaded,
	output logic                     core_reset
);
	logic                   push;
	romload_pkg::mem_addr_t push_addr;
	romload_pkg::byte_sel_t push_ds;
	romload_pkg::mem_data_t push_data;
	logic                   credit_ret;
	logic                   fifo_valid;
	romload_pkg::mem_addr_t fifo_addr;
	romload_pkg::byte_sel_t fifo_ds;
	romload_pkg::mem_data_t fifo_data;
	logic                   fifo_empty;
	logic                   pop;
	logic                   writer_idle;

	dl_byte_packer #(.FIFO_DEPTH(FIFO_DEPTH)) packer (
		.clock_49       (clock_49),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.credit_ret     (credit_ret),
		.push           (push),
		.push_addr      (push_addr),
		.push_ds        (push_ds),
		.push_data      (push_data),
		.overflow       (overflow)
	);

	dl_write_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) wr_fifo (
		.clock_49   (clock_49),
		.rst        (rst),
		.push       (push),
		.push_addr  (push_addr),
		.push_ds    (push_ds),
		.push_data  (push_data),
		.pop        (pop),
		.fifo_valid (fifo_valid),
		.fifo_addr  (fifo_addr),
		.fifo_ds    (fifo_ds),
		.fifo_data  (fifo_data),
		.credit_ret (credit_ret),
		.fifo_empty (fifo_empty)
	);

	sdram_port_writer writer (
		.clock_49    (clock_49),
		.rst         (rst),
		.fifo_valid  (fifo_valid),
		.fifo_addr   (fifo_addr),
		.fifo_ds     (fifo_ds),
		.fifo_data   (fifo_data),
		.fifo_empty  (fifo_empty),
		.mem_ack     (mem_ack),
		.pop         (pop),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ds      (mem_ds),
		.mem_data    (mem_data),
		.writer_idle (writer_idle)
	);

	core_reset_ctrl reset_ctrl (
		.clock_49       (clock_49),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.writer_idle    (writer_idle),
		.reset_req      (reset_req),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

endmodule

/* core_reset_ctrl.sv */
module core_reset_ctrl (
	input  logic clock_49,
	input  logic rst,
	input  logic ioctl_download,
	input  logic writer_idle,
	input  logic reset_req,
	output logic rom_loaded,
	output logic core_reset
);
	logic download_d;
	logic drain_wait;  // download over, writes may still be pending

	always_ff @(posedge clock_49) begin
		if (rst) begin
			download_d <= 1'b0;
			drain_wait <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_d <= ioctl_download;
			if (download_d && !ioctl_download)
				drain_wait <= 1'b1;  // falling edge
			else if (drain_wait && writer_idle)
				drain_wait <= 1'b0;
			if (drain_wait && writer_idle)
				rom_loaded <= 1'b1;  // sticky until rst
			core_reset <= reset_req || !rom_loaded;
		end
	end

endmodule

/* sdram_port_writer.sv */
module sdram_port_writer (
	input  logic                   clock_49,
	input  logic                   rst,
	input  logic                   fifo_valid,
	input  romload_pkg::mem_addr_t fifo_addr,
	input  romload_pkg::byte_sel_t fifo_ds,
	input  romload_pkg::mem_data_t fifo_data,
	input  logic                   fifo_empty,
	input  logic                   mem_ack,
	output logic                   pop,
	output logic                   mem_req,
	output romload_pkg::mem_addr_t mem_addr,
	output romload_pkg::byte_sel_t mem_ds,
	output romload_pkg::mem_data_t mem_data,
	output logic                   writer_idle
);
	romload_pkg::writer_state_t state;

	// take the head entry as soon as the port is free
	assign pop = state == romload_pkg::WR_IDLE && fifo_valid;

	assign writer_idle = state == romload_pkg::WR_IDLE && fifo_empty;

	always_ff @(posedge clock_49) begin
		if (rst) begin
			state   <= romload_pkg::WR_IDLE;
			mem_req <= 1'b0;
		end else begin
			case (state)
				romload_pkg::WR_IDLE: begin
					if (fifo_valid) begin
						mem_req <= ~mem_req;  // toggle starts the write
						state   <= romload_pkg::WR_WAIT_ACK;
					end
				end
				romload_pkg::WR_WAIT_ACK: begin
					if (mem_ack == mem_req)
						state <= romload_pkg::WR_IDLE;  // write done
				end
				default: state <= romload_pkg::WR_IDLE;
			endcase
		end
	end

	// port lines stay put until the next pop
	always_ff @(posedge clock_49) begin
		if (pop) begin
			mem_addr <= fifo_addr;
			mem_ds   <= fifo_ds;
			mem_data <= fifo_data;
		end
	end

endmodule

/* dl_write_fifo.sv */
module dl_write_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                   clock_49,
	input  logic                   rst,
	input  logic                   push,
	input  romload_pkg::mem_addr_t push_addr,
	input  romload_pkg::byte_sel_t push_ds,
	input  romload_pkg::mem_data_t push_data,
	input  logic                   pop,
	output logic                   fifo_valid,
	output romload_pkg::mem_addr_t fifo_addr,
	output romload_pkg::byte_sel_t fifo_ds,
	output romload_pkg::mem_data_t fifo_data,
	output logic                   credit_ret,
	output logic                   fifo_empty
);
	localparam int AW = $clog2(FIFO_DEPTH);

	romload_pkg::mem_addr_t addr_mem [FIFO_DEPTH];
	romload_pkg::byte_sel_t ds_mem   [FIFO_DEPTH];
	romload_pkg::mem_data_t data_mem [FIFO_DEPTH];

	logic [AW:0] wr_ptr;  // extra bit, wraps once per lap
	logic [AW:0] rd_ptr;
	logic        buf_empty;

	assign buf_empty  = wr_ptr == rd_ptr;
	assign fifo_valid = !buf_empty;
	assign fifo_empty = buf_empty && !push;  // also covers a write still arriving

	assign fifo_addr = addr_mem[rd_ptr[AW-1:0]];
	assign fifo_ds   = ds_mem[rd_ptr[AW-1:0]];
	assign fifo_data = data_mem[rd_ptr[AW-1:0]];

	// a freed slot goes straight back to the packer
	assign credit_ret = pop && fifo_valid;

	always_ff @(posedge clock_49) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;  // room guaranteed by credits
			if (credit_ret)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock_49) begin
		if (push) begin
			addr_mem[wr_ptr[AW-1:0]] <= push_addr;
			ds_mem[wr_ptr[AW-1:0]]   <= push_ds;
			data_mem[wr_ptr[AW-1:0]] <= push_data;
		end
	end

endmodule

/* dl_byte_packer.sv */
module dl_byte_packer #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                     clock_49,
	input  logic                     rst,
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  logic                     ioctl_wr,
	input  romload_pkg::ioctl_addr_t ioctl_addr,
	input  romload_pkg::rom_byte_t   ioctl_dout,
	input  logic                     credit_ret,
	output logic                     push,
	output romload_pkg::mem_addr_t   push_addr,
	output romload_pkg::byte_sel_t   push_ds,
	output romload_pkg::mem_data_t   push_data,
	output logic                     overflow
);
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	logic                     accept;
	logic                     byte_ok;
	logic                     is_gfx;
	romload_pkg::ioctl_addr_t gfx_off;
	logic                     new_even;
	romload_pkg::mem_addr_t   new_addr;
	romload_pkg::byte_sel_t   new_ds;
	logic                     hold_v;
	romload_pkg::mem_addr_t   hold_addr;
	romload_pkg::rom_byte_t   hold_data;
	logic                     pend_v;
	romload_pkg::mem_addr_t   pend_addr;
	romload_pkg::byte_sel_t   pend_ds;
	romload_pkg::mem_data_t   pend_data;
	logic                     flush;
	logic                     pair;
	logic                     defer;
	logic                     want_v;
	romload_pkg::mem_addr_t   want_addr;
	romload_pkg::byte_sel_t   want_ds;
	romload_pkg::mem_data_t   want_data;
	logic [CW-1:0]            credit_cnt;
	logic                     take;

	assign accept  = ioctl_wr && ioctl_download && ioctl_index == romload_pkg::ROM_INDEX;
	assign byte_ok = accept && !pend_v;  // bytes are spaced more than one cycle apart

	assign is_gfx   = ioctl_addr >= romload_pkg::GFX_BASE;
	assign gfx_off  = ioctl_addr - romload_pkg::GFX_BASE;
	assign new_even = !is_gfx && !ioctl_addr[0];
	assign new_addr = is_gfx ? {gfx_off[23:16], gfx_off[14:0]} : ioctl_addr[23:1];  // fold gfx
	assign new_ds   = is_gfx ? {~gfx_off[15], gfx_off[15]} : {ioctl_addr[0], ~ioctl_addr[0]};

	// held even byte leaves on the next byte or at download end
	assign flush = hold_v && !pend_v && (byte_ok || !ioctl_download);
	assign pair  = flush && byte_ok && !is_gfx && ioctl_addr[0] && ioctl_addr[23:1] == hold_addr;
	assign defer = flush && byte_ok && !pair && !new_even;  // new byte goes one cycle later

	always_comb begin
		want_v    = 1'b0;
		want_addr = hold_addr;
		want_ds   = 2'b01;  // lone even byte
		want_data = {hold_data, hold_data};
		if (pend_v) begin
			want_v    = 1'b1;
			want_addr = pend_addr;
			want_ds   = pend_ds;
			want_data = pend_data;
		end else if (flush) begin
			want_v = 1'b1;
			if (pair) begin
				want_ds   = 2'b11;
				want_data = {ioctl_dout, hold_data};
			end
		end else if (byte_ok && !new_even) begin
			want_v    = 1'b1;
			want_addr = new_addr;
			want_ds   = new_ds;
			want_data = {ioctl_dout, ioctl_dout};
		end
	end

	assign take = want_v && credit_cnt != '0;

	always_ff @(posedge clock_49) begin
		if (rst) begin
			push       <= 1'b0;
			overflow   <= 1'b0;
			credit_cnt <= CW'(FIFO_DEPTH);
			hold_v     <= 1'b0;
			pend_v     <= 1'b0;
		end else begin
			push       <= take;
			credit_cnt <= credit_cnt - CW'(take) + CW'(credit_ret);
			pend_v     <= defer;
			if (want_v && !take)
				overflow <= 1'b1;  // sticky, write is lost
			if (byte_ok && new_even)
				hold_v <= 1'b1;
			else if (flush)
				hold_v <= 1'b0;
		end
	end

	always_ff @(posedge clock_49) begin
		if (take) begin
			push_addr <= want_addr;
			push_ds   <= want_ds;
			push_data <= want_data;
		end
		if (byte_ok && new_even) begin
			hold_addr <= new_addr;
			hold_data <= ioctl_dout;
		end
		if (defer) begin
			pend_addr <= new_addr;
			pend_ds   <= new_ds;
			pend_data <= {ioctl_dout, ioctl_dout};
		end
	end

endmodule

/* romload_pkg.sv */
package romload_pkg;

	// download side, as delivered by the host byte interface
	typedef logic [24:0] ioctl_addr_t;
	typedef logic [7:0]  rom_byte_t;

	// sdram side, 16 bit words
	typedef logic [22:0] mem_addr_t;
	typedef logic [15:0] mem_data_t;
	typedef logic [1:0]  byte_sel_t;  // bit 1 is the upper byte

	// graphics roms start here in the image
	localparam ioctl_addr_t GFX_BASE = 25'h10000;

	// download index of the rom image
	localparam logic [7:0] ROM_INDEX = 8'd0;

	typedef enum logic {
		WR_IDLE,      // waiting for a buffered write
		WR_WAIT_ACK   // request toggled, ack not yet matched
	} writer_state_t;

endpackage
